// File: logic/dma_pkg.sv
// dma channel package with data widths, register offsets and status bits
`default_nettype none

package dma_pkg;

   // one transfer word and one fifo entry (word plus last flag)
   localparam int DATA_W  = 64;
   localparam int ENTRY_W = DATA_W + 1;

   // bus register word offsets
   localparam logic [1:0] REG_DAT_LO      = 2'd0;
   localparam logic [1:0] REG_DAT_HI      = 2'd1;
   localparam logic [1:0] REG_DAT_HI_LAST = 2'd2;
   localparam logic [1:0] REG_STATUS      = 2'd3;

   // status word bit positions
   localparam int ST_SRC_STOP  = 0;
   localparam int ST_SRC_START = 1;
   localparam int ST_DST_STOP  = 2;
   localparam int ST_DST_START = 3;
   localparam int ST_DST_END   = 4;
   localparam int ST_DST_EMPTY = 5;
   localparam int ST_OVERFLOW  = 6;

endpackage

`default_nettype wire

// File: logic/fifo_ctrl.sv
// fifo pointer controller keeping read/write pointers, fill level and flags
`timescale 1ns/1ns
`default_nettype none

module fifo_ctrl #(
   parameter int FIFO_AW = 4
) (
   input  wire logic               wb_clk_i,
   input  wire logic               rst_n_i,
   input  wire logic               clear_i,
   input  wire logic               wr_en_i,
   input  wire logic               rd_en_i,
   output logic      [FIFO_AW-1:0] waddr_o,
   output logic      [FIFO_AW-1:0] raddr_o,
   output logic                    empty_o,
   output logic                    full_o,
   output logic                    almost_empty_o,
   output logic                    almost_full_o,
   output logic                    half_full_o
);

   localparam logic [FIFO_AW:0] DEPTH = {1'b1, {FIFO_AW{1'b0}}};
   localparam logic [FIFO_AW:0] HALF  = DEPTH >> 1;
   localparam logic [FIFO_AW:0] ONE   = {{FIFO_AW{1'b0}}, 1'b1};

   // pointers carry one extra wrap bit
   logic [FIFO_AW:0] wr_ptr_q;
   logic [FIFO_AW:0] rd_ptr_q;
   logic [FIFO_AW:0] count_q;
   logic             wr_ok;
   logic             rd_ok;

   // refused operations leave pointers alone
   assign wr_ok = wr_en_i && !full_o;
   assign rd_ok = rd_en_i && !empty_o;

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i || clear_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr_q <= wr_ptr_q + ONE;
         end
         if (rd_ok) begin
            rd_ptr_q <= rd_ptr_q + ONE;
         end
         // net fill change, a simultaneous push and pop cancel out
         if (wr_ok && !rd_ok) begin
            count_q <= count_q + ONE;
         end else if (rd_ok && !wr_ok) begin
            count_q <= count_q - ONE;
         end
      end
   end

   assign waddr_o = wr_ptr_q[FIFO_AW-1:0];
   assign raddr_o = rd_ptr_q[FIFO_AW-1:0];

   assign empty_o = (count_q == '0);
   assign full_o  = (count_q == DEPTH);

   // at most one entry left / at most one slot free
   assign almost_empty_o = (count_q <= ONE);
   assign almost_full_o  = (count_q >= DEPTH - ONE);
   assign half_full_o    = (count_q >= HALF);

endmodule

`default_nettype wire

// File: logic/tpram.sv
// two-port ram, registered write port and combinational read port
`timescale 1ns/1ns
`default_nettype none

module tpram #(
   parameter int FIFO_AW = 4
) (
   input  wire logic                       wb_clk_i,
   input  wire logic                       we_i,
   input  wire logic [FIFO_AW-1:0]         waddr_i,
   input  wire logic [dma_pkg::ENTRY_W-1:0] wdata_i,
   input  wire logic [FIFO_AW-1:0]         raddr_i,
   output logic      [dma_pkg::ENTRY_W-1:0] rdata_o
);

   localparam int DEPTH = 1 << FIFO_AW;

   // contents only meaningful behind the controller pointers
   logic [dma_pkg::ENTRY_W-1:0] mem [0:DEPTH-1];

   always_ff @(posedge wb_clk_i) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // head shows up as soon as the read pointer moves
   assign rdata_o = mem[raddr_i];

endmodule

`default_nettype wire

// File: logic/dma_chan.sv
// dma channel with source and destination fifos and burst pacing hints
`timescale 1ns/1ns
`default_nettype none

module dma_chan #(
   parameter int FIFO_AW = 4
) (
   input  wire logic                      wb_clk_i,
   input  wire logic                      rst_n_i,
   input  wire logic                      m_reset_i,
   input  wire logic                      ss_xfer0_i,
   input  wire logic                      ss_last0_i,
   input  wire logic [dma_pkg::DATA_W-1:0] ss_dat0_i,
   input  wire logic                      ss_xfer1_i,
   input  wire logic                      m_src_getn_i,
   input  wire logic                      m_dst_putn_i,
   input  wire logic [dma_pkg::DATA_W-1:0] m_dst_i,
   input  wire logic                      m_dst_last_i,
   input  wire logic                      m_endn_i,
   output logic      [dma_pkg::DATA_W-1:0] ss_dat1_o,
   output logic                           ss_end1_o,
   output logic                           ss_stop0_o,
   output logic                           ss_start0_o,
   output logic                           ss_stop1_o,
   output logic                           ss_start1_o,
   output logic                           src_full_o,
   output logic                           dst_empty_o,
   output logic      [dma_pkg::DATA_W-1:0] m_src_o,
   output logic                           m_src_last_o,
   output logic                           m_src_almost_empty_o,
   output logic                           m_src_empty_o,
   output logic                           m_dst_almost_full_o,
   output logic                           m_dst_full_o
);

   logic [FIFO_AW-1:0]          src_waddr, src_raddr, dst_waddr, dst_raddr;
   logic [dma_pkg::ENTRY_W-1:0] src_rdata, dst_rdata;
   logic src_we, dst_we, dst_re;
   logic src_almost_full, src_half_full, dst_almost_empty, dst_half_full;

   // bus pushes into source, module pushes into destination
   assign src_we = ss_xfer0_i && !src_full_o;
   assign dst_we = !m_dst_putn_i && !m_dst_full_o;
   assign dst_re = ss_xfer1_i && !dst_empty_o;

   fifo_ctrl #(.FIFO_AW(FIFO_AW)) u_src_ctrl (
      .wb_clk_i, .rst_n_i, .clear_i(m_reset_i), .wr_en_i(src_we), .rd_en_i(!m_src_getn_i),
      .waddr_o(src_waddr), .raddr_o(src_raddr), .empty_o(m_src_empty_o),
      .full_o(src_full_o), .almost_empty_o(m_src_almost_empty_o),
      .almost_full_o(src_almost_full), .half_full_o(src_half_full));

   tpram #(.FIFO_AW(FIFO_AW)) u_src_ram (
      .wb_clk_i, .we_i(src_we), .waddr_i(src_waddr), .wdata_i({ss_last0_i, ss_dat0_i}),
      .raddr_i(src_raddr), .rdata_o(src_rdata));

   fifo_ctrl #(.FIFO_AW(FIFO_AW)) u_dst_ctrl (
      .wb_clk_i, .rst_n_i, .clear_i(m_reset_i), .wr_en_i(dst_we), .rd_en_i(dst_re),
      .waddr_o(dst_waddr), .raddr_o(dst_raddr), .empty_o(dst_empty_o),
      .full_o(m_dst_full_o), .almost_empty_o(dst_almost_empty),
      .almost_full_o(m_dst_almost_full_o), .half_full_o(dst_half_full));

   tpram #(.FIFO_AW(FIFO_AW)) u_dst_ram (
      .wb_clk_i, .we_i(dst_we), .waddr_i(dst_waddr), .wdata_i({m_dst_last_i, m_dst_i}),
      .raddr_i(dst_raddr), .rdata_o(dst_rdata));

   // entry layout is {last, word}
   assign m_src_o      = src_rdata[dma_pkg::DATA_W-1:0];
   assign m_src_last_o = src_rdata[dma_pkg::DATA_W];
   assign ss_dat1_o    = dst_rdata[dma_pkg::DATA_W-1:0];
   assign ss_end1_o    = dst_rdata[dma_pkg::DATA_W];

   // pacing hints for the burst engine
   assign ss_stop0_o  = src_almost_full;
   assign ss_start0_o = !src_half_full;
   assign ss_stop1_o  = dst_almost_empty;
   // end request flushes whatever is left in the destination
   assign ss_start1_o = dst_half_full || (!m_endn_i && !dst_empty_o);

endmodule

`default_nettype wire

// File: logic/dma_wb_port.sv
// wishbone classic slave that packs 64-bit words and serves the status register
`timescale 1ns/1ns
`default_nettype none

module dma_wb_port (
   input  wire logic                      wb_clk_i,
   input  wire logic                      rst_n_i,
   input  wire logic                      wb_cyc_i,
   input  wire logic                      wb_stb_i,
   input  wire logic                      wb_we_i,
   input  wire logic [1:0]                wb_adr_i,
   input  wire logic [31:0]               wb_dat_i,
   input  wire logic                      m_reset_i,
   input  wire logic [dma_pkg::DATA_W-1:0] ss_dat1_i,
   input  wire logic                      ss_end1_i,
   input  wire logic                      ss_stop0_i,
   input  wire logic                      ss_start0_i,
   input  wire logic                      ss_stop1_i,
   input  wire logic                      ss_start1_i,
   input  wire logic                      src_full_i,
   input  wire logic                      dst_empty_i,
   output logic                           wb_ack_o,
   output logic      [31:0]               wb_dat_o,
   output logic                           ss_xfer0_o,
   output logic                           ss_last0_o,
   output logic      [dma_pkg::DATA_W-1:0] ss_dat0_o,
   output logic                           ss_xfer1_o
);

   logic        ack_q;
   logic        ovf_q;
   logic [31:0] lo_q;
   logic        req;
   logic        wr_cyc;
   logic        rd_cyc;
   logic        hi_wr;
   logic [31:0] status;

   // new request only when ack is not already out
   assign req = wb_cyc_i && wb_stb_i && !ack_q;

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req;
      end
   end

   assign wb_ack_o = ack_q;

   // side effects take place on the ack cycle
   assign wr_cyc = ack_q && wb_we_i;
   assign rd_cyc = ack_q && !wb_we_i;
   assign hi_wr  = (wb_adr_i == dma_pkg::REG_DAT_HI) ||
                   (wb_adr_i == dma_pkg::REG_DAT_HI_LAST);

   // low half staging
   always_ff @(posedge wb_clk_i) begin
      if (wr_cyc && wb_adr_i == dma_pkg::REG_DAT_LO) begin
         lo_q <= wb_dat_i;
      end
   end

   assign ss_xfer0_o = wr_cyc && hi_wr;
   assign ss_last0_o = (wb_adr_i == dma_pkg::REG_DAT_HI_LAST);
   assign ss_dat0_o  = {wb_dat_i, lo_q};
   assign ss_xfer1_o = rd_cyc && (wb_adr_i == dma_pkg::REG_DAT_HI);

   // sticky overflow, a push into a full source is lost
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i || m_reset_i) begin
         ovf_q <= 1'b0;
      end else if (ss_xfer0_o && src_full_i) begin
         ovf_q <= 1'b1;
      end
   end

   always_comb begin
      status                        = '0;
      status[dma_pkg::ST_SRC_STOP]  = ss_stop0_i;
      status[dma_pkg::ST_SRC_START] = ss_start0_i;
      status[dma_pkg::ST_DST_STOP]  = ss_stop1_i;
      status[dma_pkg::ST_DST_START] = ss_start1_i;
      status[dma_pkg::ST_DST_END]   = ss_end1_i && !dst_empty_i;
      status[dma_pkg::ST_DST_EMPTY] = dst_empty_i;
      status[dma_pkg::ST_OVERFLOW]  = ovf_q;
   end

   // empty destination reads back as zero
   always_comb begin
      case (wb_adr_i)
         dma_pkg::REG_DAT_LO:      wb_dat_o = dst_empty_i ? '0 : ss_dat1_i[31:0];
         dma_pkg::REG_DAT_HI:      wb_dat_o = dst_empty_i ? '0 : ss_dat1_i[63:32];
         dma_pkg::REG_DAT_HI_LAST: wb_dat_o = {31'd0, ss_end1_i && !dst_empty_i};
         default:                  wb_dat_o = status;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/dma_chan_top.sv
// dma channel top joining the wishbone port and the fifo channel
`timescale 1ns/1ns
`default_nettype none

module dma_chan_top #(
   parameter int FIFO_AW = 4
) (
   input  wire logic                      wb_clk_i,
   input  wire logic                      rst_n_i,
   input  wire logic                      wb_cyc_i,
   input  wire logic                      wb_stb_i,
   input  wire logic                      wb_we_i,
   input  wire logic [1:0]                wb_adr_i,
   input  wire logic [31:0]               wb_dat_i,
   output logic      [31:0]               wb_dat_o,
   output logic                           wb_ack_o,
   input  wire logic                      m_reset_i,
   input  wire logic                      m_src_getn_i,
   output logic      [dma_pkg::DATA_W-1:0] m_src_o,
   output logic                           m_src_last_o,
   output logic                           m_src_almost_empty_o,
   output logic                           m_src_empty_o,
   input  wire logic                      m_dst_putn_i,
   input  wire logic [dma_pkg::DATA_W-1:0] m_dst_i,
   input  wire logic                      m_dst_last_i,
   output logic                           m_dst_almost_full_o,
   output logic                           m_dst_full_o,
   input  wire logic                      m_endn_i
);

   logic                       ss_xfer0, ss_last0, ss_xfer1, ss_end1;
   logic [dma_pkg::DATA_W-1:0] ss_dat0, ss_dat1;
   logic ss_stop0, ss_start0, ss_stop1, ss_start1, src_full, dst_empty;

   dma_wb_port u_port (
      .wb_clk_i, .rst_n_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
      .m_reset_i, .ss_dat1_i(ss_dat1), .ss_end1_i(ss_end1),
      .ss_stop0_i(ss_stop0), .ss_start0_i(ss_start0),
      .ss_stop1_i(ss_stop1), .ss_start1_i(ss_start1),
      .src_full_i(src_full), .dst_empty_i(dst_empty),
      .wb_ack_o, .wb_dat_o, .ss_xfer0_o(ss_xfer0), .ss_last0_o(ss_last0),
      .ss_dat0_o(ss_dat0), .ss_xfer1_o(ss_xfer1));

   dma_chan #(.FIFO_AW(FIFO_AW)) u_chan (
      .wb_clk_i, .rst_n_i, .m_reset_i,
      .ss_xfer0_i(ss_xfer0), .ss_last0_i(ss_last0), .ss_dat0_i(ss_dat0),
      .ss_xfer1_i(ss_xfer1), .m_src_getn_i, .m_dst_putn_i, .m_dst_i, .m_dst_last_i,
      .m_endn_i, .ss_dat1_o(ss_dat1), .ss_end1_o(ss_end1),
      .ss_stop0_o(ss_stop0), .ss_start0_o(ss_start0),
      .ss_stop1_o(ss_stop1), .ss_start1_o(ss_start1),
      .src_full_o(src_full), .dst_empty_o(dst_empty),
      .m_src_o, .m_src_last_o, .m_src_almost_empty_o, .m_src_empty_o,
      .m_dst_almost_full_o, .m_dst_full_o);

endmodule

`default_nettype wire

// File: testbench/tb_dma_chan_top.sv
// directed testbench for the dma channel, driving the wishbone and module sides
`timescale 1ns/1ns
`default_nettype none

module tb_dma_chan_top;

   localparam int FIFO_AW   = 4;
   localparam int DEPTH     = 1 << FIFO_AW;
   localparam int NUM_TESTS = 5;

   logic        wb_clk_i = 1'b0;
   logic        rst_n_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
   logic [1:0]  wb_adr_i;
   logic [31:0] wb_dat_i, wb_dat_o;
   logic        m_reset_i, m_src_getn_i, m_src_last_o, m_src_almost_empty_o, m_src_empty_o;
   logic        m_dst_putn_i, m_dst_last_i, m_dst_almost_full_o, m_dst_full_o, m_endn_i;
   logic [63:0] m_src_o, m_dst_i;

   // expected contents, entry is {last, word}
   logic [64:0] src_q[$];
   logic [64:0] dst_q[$];
   logic        ovf_exp;
   logic        endn_exp;
   integer      seed = 69686;

   dma_chan_top #(.FIFO_AW(FIFO_AW)) DUT (
      .wb_clk_i, .rst_n_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
      .wb_dat_o, .wb_ack_o, .m_reset_i, .m_src_getn_i, .m_src_o, .m_src_last_o,
      .m_src_almost_empty_o, .m_src_empty_o, .m_dst_putn_i, .m_dst_i, .m_dst_last_i,
      .m_dst_almost_full_o, .m_dst_full_o, .m_endn_i);

   always #10 wb_clk_i = ~wb_clk_i;

   task automatic check_equal(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAIL at %0t ns: %s, got %h expected %h", $time, what, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "mismatch");
      end
   endtask

   function automatic logic [63:0] rand_word();
      return {$random(seed), $random(seed)};
   endfunction

   // status word as the hint rules give it for the model fill levels
   function automatic logic [31:0] expected_status();
      logic [31:0] s;
      int          sc;
      int          dc;
      sc = src_q.size();
      dc = dst_q.size();
      s = '0;
      s[dma_pkg::ST_SRC_STOP]  = (sc >= DEPTH - 1);
      s[dma_pkg::ST_SRC_START] = (sc < DEPTH / 2);
      s[dma_pkg::ST_DST_STOP]  = (dc <= 1);
      s[dma_pkg::ST_DST_START] = (dc >= DEPTH / 2) || (!endn_exp && dc > 0);
      s[dma_pkg::ST_DST_END]   = (dc > 0) ? dst_q[0][64] : 1'b0;
      s[dma_pkg::ST_DST_EMPTY] = (dc == 0);
      s[dma_pkg::ST_OVERFLOW]  = ovf_exp;
      return s;
   endfunction

   task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
      int waits;
      @(posedge wb_clk_i);
      wb_cyc_i <= 1'b1;
      wb_stb_i <= 1'b1;
      wb_we_i  <= we;
      wb_adr_i <= adr;
      wb_dat_i <= wdat;
      waits = 0;
      do begin
         @(negedge wb_clk_i);
         waits++;
      end while (!wb_ack_o);
      check_equal("ack latency", waits, 2);
      rdat = wb_dat_o;
      @(posedge wb_clk_i);
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      wb_we_i  <= 1'b0;
   endtask

   task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
      logic [31:0] ignored;
      bus_cycle(1'b1, adr, dat, ignored);
   endtask

   task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
      bus_cycle(1'b0, adr, 32'd0, dat);
   endtask

   task automatic check_status();
      logic [31:0] st;
      wb_read(dma_pkg::REG_STATUS, st);
      check_equal("status", st, expected_status());
   endtask

   // two bus writes make one source push, a full fifo drops it
   task automatic push_word(input logic [63:0] data, input logic last);
      wb_write(dma_pkg::REG_DAT_LO, data[31:0]);
      wb_write(last ? dma_pkg::REG_DAT_HI_LAST : dma_pkg::REG_DAT_HI, data[63:32]);
      if (src_q.size() < DEPTH) begin
         src_q.push_back({last, data});
      end else begin
         ovf_exp = 1'b1;
      end
   endtask

   // empty destination reads as zero on every register
   task automatic read_dst_word();
      logic [31:0] lo;
      logic [31:0] hi;
      logic [31:0] lst;
      logic [64:0] exp;
      exp = '0;
      if (dst_q.size() > 0) begin
         exp = dst_q.pop_front();
      end
      wb_read(dma_pkg::REG_DAT_LO, lo);
      wb_read(dma_pkg::REG_DAT_HI_LAST, lst);
      wb_read(dma_pkg::REG_DAT_HI, hi);
      check_equal("destination low half", lo, exp[31:0]);
      check_equal("destination last flag", lst, exp[64]);
      check_equal("destination high half", hi, exp[63:32]);
   endtask

   task automatic m_get();
      logic [64:0] exp;
      @(negedge wb_clk_i);
      check_equal("source empty flag", m_src_empty_o, 1'b0);
      exp = src_q.pop_front();
      check_equal("source word", m_src_o, exp[63:0]);
      check_equal("source last flag", m_src_last_o, exp[64]);
      @(posedge wb_clk_i);
      m_src_getn_i <= 1'b0;
      @(posedge wb_clk_i);
      m_src_getn_i <= 1'b1;
   endtask

   task automatic m_put(input logic [63:0] data, input logic last);
      @(posedge wb_clk_i);
      m_dst_putn_i <= 1'b0;
      m_dst_i      <= data;
      m_dst_last_i <= last;
      @(posedge wb_clk_i);
      m_dst_putn_i <= 1'b1;
      if (dst_q.size() < DEPTH) begin
         dst_q.push_back({last, data});
      end
   endtask

   task automatic check_src_empty(input logic exp);
      @(negedge wb_clk_i);
      check_equal("source empty output", m_src_empty_o, exp);
   endtask

   task automatic test_reset_state();
      check_status();
      check_src_empty(1'b1);
   endtask

   task automatic test_bus_to_module();
      for (int i = 0; i < 8; i++) begin
         push_word(rand_word(), (i % 4) == 3);
      end
      while (src_q.size() > 0) begin
         m_get();
      end
      check_src_empty(1'b1);
   endtask

   task automatic test_module_to_bus();
      read_dst_word();
      check_status();
      for (int i = 0; i < 6; i++) begin
         m_put(rand_word(), $random(seed) & 1);
      end
      while (dst_q.size() > 0) begin
         read_dst_word();
      end
      read_dst_word();
   endtask

   task automatic test_flag_levels();
      for (int i = 0; i < DEPTH; i++) begin
         push_word(rand_word(), 1'b0);
         check_status();
         @(negedge wb_clk_i);
         check_equal("source almost empty output", m_src_almost_empty_o,
                     src_q.size() <= 1);
      end
      while (src_q.size() > 0) begin
         m_get();
      end
      check_src_empty(1'b1);
      for (int i = 0; i < DEPTH; i++) begin
         m_put(rand_word(), i[0]);
         @(negedge wb_clk_i);
         check_equal("destination full output", m_dst_full_o, dst_q.size() == DEPTH);
         check_equal("destination almost full output", m_dst_almost_full_o,
                     dst_q.size() >= DEPTH - 1);
         check_status();
      end
      while (dst_q.size() > 1) begin
         read_dst_word();
      end
      check_status();
      // end request with a single word left
      @(posedge wb_clk_i);
      m_endn_i <= 1'b0;
      endn_exp = 1'b0;
      check_status();
      read_dst_word();
      check_status();
      @(posedge wb_clk_i);
      m_endn_i <= 1'b1;
      endn_exp = 1'b1;
   endtask

   task automatic test_overflow_clear();
      for (int i = 0; i <= DEPTH; i++) begin
         push_word(rand_word(), (i % 4) == 3);
      end
      check_status();
      while (src_q.size() > 0) begin
         m_get();
      end
      check_src_empty(1'b1);
      push_word(rand_word(), 1'b1);
      m_put(rand_word(), 1'b1);
      check_status();
      @(posedge wb_clk_i);
      m_reset_i <= 1'b1;
      @(posedge wb_clk_i);
      m_reset_i <= 1'b0;
      src_q.delete();
      dst_q.delete();
      ovf_exp = 1'b0;
      check_src_empty(1'b1);
      check_status();
   endtask

   initial begin
      rst_n_i      = 1'b0;
      wb_cyc_i     = 1'b0;
      wb_stb_i     = 1'b0;
      wb_we_i      = 1'b0;
      wb_adr_i     = 2'd0;
      wb_dat_i     = 32'd0;
      m_reset_i    = 1'b0;
      m_src_getn_i = 1'b1;
      m_dst_putn_i = 1'b1;
      m_dst_i      = 64'd0;
      m_dst_last_i = 1'b0;
      m_endn_i     = 1'b1;
      ovf_exp      = 1'b0;
      endn_exp     = 1'b1;
      repeat (4) @(posedge wb_clk_i);
      rst_n_i <= 1'b1;
      test_reset_state();
      test_bus_to_module();
      test_module_to_bus();
      test_flag_levels();
      test_overflow_clear();
      $display("Simulation finished: PASS");
      $finish;
   end

   // watchdog, 200 cycles per test
   initial begin
      repeat (NUM_TESTS * 200) @(posedge wb_clk_i);
      $display("ERROR: the watchdog expired before the tests completed");
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire

// File: dma_chan_top.f
logic/dma_pkg.sv
logic/fifo_ctrl.sv
logic/tpram.sv
logic/dma_chan.sv
logic/dma_wb_port.sv
logic/dma_chan_top.sv
testbench/tb_dma_chan_top.sv
